/* rv_core_config.svh */
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// Data and address width
`define XLEN 32

// Architectural registers, 5-bit indices
`define REG_COUNT 32

`define RESET_PC 32'h0000_0000

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`endif

/* rv_core_pkg.sv */
`include "rv_core_config.svh"

package rv_core_pkg;

    // Major opcodes kept by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        SRA,
        PASS_B
    } alu_op_e;

    typedef enum logic {
        WB_ALU,
        WB_LINK
    } wb_sel_e;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
    } if_id_t;

    typedef struct packed {
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        opcode_e          opcode;
        logic [2:0]       funct3;
        logic             funct7_5;
        logic             reg_write;
        logic             imm_b;
        logic             pc_a;
        logic             branch;
        logic             jump;
        wb_sel_e          wb_sel;
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] link;
        logic [4:0]       rd;
        logic             reg_write;
        wb_sel_e          wb_sel;
    } ex_mem_t;

    // Same layout one stage later
    typedef ex_mem_t mem_wb_t;

    typedef struct packed {
        logic             en;
        logic [4:0]       rd;
        logic [`XLEN-1:0] data;
    } rf_write_t;

endpackage

/* fetch_stage.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module fetch_stage import rv_core_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             clk_enable,
    input  logic             redirect,
    input  logic [`XLEN-1:0] redirect_target,
    input  logic [31:0]      instr,
    output logic [`XLEN-1:0] pc,
    output if_id_t           if_id
);

    logic [`XLEN-1:0] next_pc;

    assign next_pc = redirect ? redirect_target : pc + `XLEN'(4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `RESET_PC;
        end else if (clk_enable) begin
            pc <= next_pc;
        end
    end

    // Instruction behind a taken redirect is dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id.pc    <= `RESET_PC;
            if_id.instr <= `NOP_INSTR;
        end else if (clk_enable) begin
            if_id.pc    <= pc;
            if_id.instr <= redirect ? `NOP_INSTR : instr;
        end
    end

endmodule

/* decode_stage.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module decode_stage import rv_core_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             clk_enable,
    input  if_id_t           if_id,
    input  logic             flush,
    input  rf_write_t        rf_write,
    input  logic [4:0]       debug_reg_addr,
    output logic [`XLEN-1:0] debug_reg_data,
    output id_ex_t           id_ex
);

    logic [31:0]      instr;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    logic [`XLEN-1:0] i_imm;
    logic [`XLEN-1:0] u_imm;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] j_imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] regs [`REG_COUNT];
    id_ex_t           id_ex_next;

    // x0 reads zero, a write in WB shows through in the same cycle
    function automatic logic [`XLEN-1:0] rf_read(
        input logic [4:0]       addr,
        input logic [`XLEN-1:0] stored,
        input rf_write_t        wr
    );
        if (addr == 5'd0) begin
            return '0;
        end else if (wr.en && wr.rd == addr) begin
            return wr.data;
        end
        return stored;
    endfunction

    assign instr = if_id.instr;
    assign rs1   = instr[19:15];
    assign rs2   = instr[24:20];
    assign rd    = instr[11:7];

    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign u_imm = {instr[31:12], 12'b0};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    assign rs1_data       = rf_read(rs1, regs[rs1], rf_write);
    assign rs2_data       = rf_read(rs2, regs[rs2], rf_write);
    assign debug_reg_data = rf_read(debug_reg_addr, regs[debug_reg_addr], rf_write);

    always_comb begin
        id_ex_next          = '0;
        id_ex_next.pc       = if_id.pc;
        id_ex_next.rs1_data = rs1_data;
        id_ex_next.rs2_data = rs2_data;
        id_ex_next.rs1      = rs1;
        id_ex_next.rs2      = rs2;
        id_ex_next.rd       = rd;
        id_ex_next.opcode   = opcode_e'(instr[6:0]);
        id_ex_next.funct3   = instr[14:12];
        id_ex_next.funct7_5 = instr[30];
        case (instr[6:0])
            OP: begin
                id_ex_next.reg_write = 1'b1;
            end
            OP_IMM: begin
                id_ex_next.reg_write = 1'b1;
                id_ex_next.imm_b     = 1'b1;
                id_ex_next.imm       = i_imm;
            end
            LUI: begin
                id_ex_next.reg_write = 1'b1;
                id_ex_next.imm_b     = 1'b1;
                id_ex_next.imm       = u_imm;
            end
            BRANCH: begin
                id_ex_next.branch = 1'b1;
                id_ex_next.imm    = b_imm;
            end
            JAL: begin
                id_ex_next.reg_write = 1'b1;
                id_ex_next.jump      = 1'b1;
                id_ex_next.pc_a      = 1'b1;
                id_ex_next.imm_b     = 1'b1;
                id_ex_next.wb_sel    = WB_LINK;
                id_ex_next.imm       = j_imm;
            end
            // Unsupported opcode turns into a bubble
            default: begin
                id_ex_next = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (clk_enable && rf_write.en && rf_write.rd != 5'd0) begin
            regs[rf_write.rd] <= rf_write.data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (clk_enable) begin
            id_ex <= flush ? id_ex_t'('0) : id_ex_next;
        end
    end

endmodule

/* forward_unit.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module forward_unit import rv_core_pkg::*; (
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    input  mem_wb_t    mem_wb,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b
);

    // 2'b10 takes MEM, 2'b01 takes WB, 2'b00 keeps the register file value
    function automatic logic [1:0] pick_source(
        input logic [4:0] rs,
        input ex_mem_t    mem_stage,
        input mem_wb_t    wb_stage
    );
        if (rs == 5'd0) begin
            return 2'b00;
        end else if (mem_stage.reg_write && mem_stage.rd == rs) begin
            // Youngest producer wins
            return 2'b10;
        end else if (wb_stage.reg_write && wb_stage.rd == rs) begin
            return 2'b01;
        end
        return 2'b00;
    endfunction

    assign fwd_a = pick_source(id_ex.rs1, ex_mem, mem_wb);
    assign fwd_b = pick_source(id_ex.rs2, ex_mem, mem_wb);

endmodule

/* execute_stage.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module execute_stage import rv_core_pkg::*; (
    input  id_ex_t           id_ex,
    input  logic [1:0]       fwd_a,
    input  logic [1:0]       fwd_b,
    input  logic [`XLEN-1:0] mem_value,
    input  logic [`XLEN-1:0] wb_value,
    output ex_mem_t          ex_out,
    output logic             redirect,
    output logic [`XLEN-1:0] redirect_target
);

    alu_op_e          alu_op;
    logic [`XLEN-1:0] rs1_val;
    logic [`XLEN-1:0] rs2_val;
    logic [`XLEN-1:0] src_a;
    logic [`XLEN-1:0] src_b;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] alu_result;
    logic             branch_taken;

    function automatic logic [`XLEN-1:0] fwd_mux(
        input logic [1:0]       sel,
        input logic [`XLEN-1:0] rf_val,
        input logic [`XLEN-1:0] mem_val,
        input logic [`XLEN-1:0] wb_val
    );
        case (sel)
            2'b10:   return mem_val;
            2'b01:   return wb_val;
            default: return rf_val;
        endcase
    endfunction

    always_comb begin
        alu_op = ADD;
        case (id_ex.opcode)
            OP, OP_IMM: begin
                case (id_ex.funct3)
                    // SUB only exists in the register form
                    3'b000:  alu_op = (id_ex.opcode == OP && id_ex.funct7_5) ? SUB : ADD;
                    3'b001:  alu_op = SLL;
                    3'b010:  alu_op = SLT;
                    3'b011:  alu_op = SLTU;
                    3'b100:  alu_op = XOR;
                    3'b101:  alu_op = id_ex.funct7_5 ? SRA : SRL;
                    3'b110:  alu_op = OR;
                    default: alu_op = AND;
                endcase
            end
            LUI:     alu_op = PASS_B;
            BRANCH:  alu_op = SUB;
            default: alu_op = ADD;
        endcase
    end

    assign rs1_val = fwd_mux(fwd_a, id_ex.rs1_data, mem_value, wb_value);
    assign rs2_val = fwd_mux(fwd_b, id_ex.rs2_data, mem_value, wb_value);
    assign src_a   = id_ex.pc_a ? id_ex.pc : rs1_val;
    assign src_b   = id_ex.imm_b ? id_ex.imm : rs2_val;
    assign shamt   = src_b[4:0];

    always_comb begin
        case (alu_op)
            ADD:     alu_result = src_a + src_b;
            SUB:     alu_result = src_a - src_b;
            AND:     alu_result = src_a & src_b;
            OR:      alu_result = src_a | src_b;
            XOR:     alu_result = src_a ^ src_b;
            SLT:     alu_result = {{(`XLEN-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            SLTU:    alu_result = {{(`XLEN-1){1'b0}}, src_a < src_b};
            SLL:     alu_result = src_a << shamt;
            SRL:     alu_result = src_a >> shamt;
            SRA:     alu_result = $unsigned($signed(src_a) >>> shamt);
            default: alu_result = src_b;
        endcase
    end

    // BEQ when funct3[0] is clear, BNE when set
    assign branch_taken = id_ex.branch &&
                          (id_ex.funct3[0] ? (alu_result != '0) : (alu_result == '0));

    assign redirect        = id_ex.jump || branch_taken;
    assign redirect_target = id_ex.pc + id_ex.imm;

    assign ex_out.result    = alu_result;
    assign ex_out.link      = id_ex.pc + `XLEN'(4);
    assign ex_out.rd        = id_ex.rd;
    assign ex_out.reg_write = id_ex.reg_write;
    assign ex_out.wb_sel    = id_ex.wb_sel;

endmodule

/* retire_stage.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module retire_stage import rv_core_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             clk_enable,
    input  ex_mem_t          ex_in,
    output ex_mem_t          ex_mem,
    output mem_wb_t          mem_wb,
    output logic [`XLEN-1:0] mem_value,
    output rf_write_t        rf_write
);

    function automatic logic [`XLEN-1:0] wb_data(input ex_mem_t stage);
        return (stage.wb_sel == WB_LINK) ? stage.link : stage.result;
    endfunction

    // No data memory, so MEM only passes the result on
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
            mem_wb <= '0;
        end else if (clk_enable) begin
            ex_mem <= ex_in;
            mem_wb <= ex_mem;
        end
    end

    assign mem_value = wb_data(ex_mem);

    assign rf_write.en   = mem_wb.reg_write;
    assign rf_write.rd   = mem_wb.rd;
    assign rf_write.data = wb_data(mem_wb);

endmodule

/* rv_core.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_core import rv_core_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             clk_enable,
    input  logic [31:0]      instr,
    output logic [`XLEN-1:0] debug_pc,
    input  logic [4:0]       debug_reg_addr,
    output logic [`XLEN-1:0] debug_reg_data
);

    if_id_t           if_id;
    id_ex_t           id_ex;
    ex_mem_t          ex_out;
    ex_mem_t          ex_mem;
    mem_wb_t          mem_wb;
    rf_write_t        rf_write;
    logic [1:0]       fwd_a;
    logic [1:0]       fwd_b;
    logic [`XLEN-1:0] mem_value;
    logic             redirect;
    logic [`XLEN-1:0] redirect_target;

    fetch_stage fetch_stage_inst (
        .clk             (clk),
        .arst_n          (arst_n),
        .clk_enable      (clk_enable),
        .redirect        (redirect),
        .redirect_target (redirect_target),
        .instr           (instr),
        .pc              (debug_pc),
        .if_id           (if_id)
    );

    // A taken redirect also squashes the instruction in ID
    decode_stage decode_stage_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .clk_enable     (clk_enable),
        .if_id          (if_id),
        .flush          (redirect),
        .rf_write       (rf_write),
        .debug_reg_addr (debug_reg_addr),
        .debug_reg_data (debug_reg_data),
        .id_ex          (id_ex)
    );

    forward_unit forward_unit_inst (
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .fwd_a  (fwd_a),
        .fwd_b  (fwd_b)
    );

    execute_stage execute_stage_inst (
        .id_ex           (id_ex),
        .fwd_a           (fwd_a),
        .fwd_b           (fwd_b),
        .mem_value       (mem_value),
        .wb_value        (rf_write.data),
        .ex_out          (ex_out),
        .redirect        (redirect),
        .redirect_target (redirect_target)
    );

    retire_stage retire_stage_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .clk_enable (clk_enable),
        .ex_in      (ex_out),
        .ex_mem     (ex_mem),
        .mem_wb     (mem_wb),
        .mem_value  (mem_value),
        .rf_write   (rf_write)
    );

endmodule

/* rv_core_tb.sv */
`timescale 1ns/10ps
`include "rv_core_config.svh"

module rv_core_tb;

    localparam int NUM_TESTS      = 8;
    localparam int PROG_WORDS     = 8;
    localparam int RUN_CYCLES     = 40;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (5 + RUN_CYCLES + 32) + 50;

    logic             clk;
    logic             arst_n;
    logic             clk_enable;
    logic [31:0]      instr;
    logic [`XLEN-1:0] debug_pc;
    logic [4:0]       debug_reg_addr;
    logic [`XLEN-1:0] debug_reg_data;

    // One row per test with program, registers to read back and their values
    logic [31:0] prog      [NUM_TESTS][PROG_WORDS];
    logic [4:0]  check_reg [NUM_TESTS][32];
    logic [31:0] check_val [NUM_TESTS][32];
    int          n_checks  [NUM_TESTS];
    bit          pause_run [NUM_TESTS];
    string       test_name [NUM_TESTS];

    int          cur_test;
    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] lcg_state;
    logic [31:0] held_pc;

    rv_core rv_core_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .clk_enable     (clk_enable),
        .instr          (instr),
        .debug_pc       (debug_pc),
        .debug_reg_addr (debug_reg_addr),
        .debug_reg_data (debug_reg_data)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                             input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [4:0] rd, input logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // RV32I register-register arithmetic
    function automatic logic [31:0] rv_alu(input logic [2:0] f3, input logic f7_5,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return f7_5 ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (f7_5) return $unsigned($signed(a) >>> b[4:0]);
                return a >> b[4:0];
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] fetch_word(input logic [31:0] pc);
        if (pc[31:2] < PROG_WORDS) return prog[cur_test][pc[4:2]];
        return `NOP_INSTR;
    endfunction

    task automatic add_check(input int t, input logic [4:0] r, input logic [31:0] v);
        check_reg[t][n_checks[t]] = r;
        check_val[t][n_checks[t]] = v;
        n_checks[t]++;
    endtask

    // LUI then ADDI with the upper part rounded for the sign-extended low part
    task automatic load_const(input int t, input int slot, input logic [4:0] rd,
                              input logic [31:0] value);
        logic [31:0] upper;
        upper = value + 32'h800;
        prog[t][slot]     = enc_lui(rd, upper[31:12]);
        prog[t][slot + 1] = enc_addi(rd, rd, value[11:0]);
    endtask

    task automatic build_random_row(input int t, input string name, input logic [11:0] f3s,
                                    input logic [3:0] f7s, input logic [3:0] swaps);
        logic [31:0] a;
        logic [31:0] b;
        logic [2:0]  f3;
        a = next_rand();
        b = next_rand();
        test_name[t] = name;
        load_const(t, 0, 1, a);
        load_const(t, 2, 2, b);
        add_check(t, 1, a);
        add_check(t, 2, b);
        for (int k = 0; k < 4; k++) begin
            f3 = f3s[3*k +: 3];
            prog[t][4 + k] = enc_r({1'b0, f7s[k], 5'b0}, swaps[k] ? 5'd1 : 5'd2,
                                   swaps[k] ? 5'd2 : 5'd1, f3, 3 + k);
            add_check(t, 3 + k, rv_alu(f3, f7s[k], swaps[k] ? b : a, swaps[k] ? a : b));
        end
    endtask

    task automatic build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            n_checks[t]  = 0;
            pause_run[t] = 1'b0;
            for (int w = 0; w < PROG_WORDS; w++) begin
                prog[t][w] = `NOP_INSTR;
            end
        end
        test_name[0] = "reset";
        for (int r = 0; r < 32; r++) begin
            add_check(0, r, 32'h0);
        end
        // Dependent chain through MEM, WB and the ID write-through
        test_name[1] = "forward chain";
        prog[1][0] = enc_addi(1, 0, 5);
        prog[1][1] = enc_addi(2, 1, 7);
        prog[1][2] = enc_r(7'h00, 1, 2, 3'b000, 3);
        prog[1][3] = enc_r(7'h00, 1, 3, 3'b000, 4);
        prog[1][4] = enc_r(7'h00, 4, 4, 3'b000, 5);
        prog[1][5] = enc_addi(6, 5, -50);
        prog[1][6] = enc_r(7'h20, 3, 6, 3'b000, 7);
        prog[1][7] = enc_r(7'h00, 2, 7, 3'b000, 8);
        add_check(1, 1, 32'd5);
        add_check(1, 2, 32'd12);
        add_check(1, 3, 32'd17);
        add_check(1, 4, 32'd22);
        add_check(1, 5, 32'd44);
        add_check(1, 6, 32'hFFFF_FFFA);
        add_check(1, 7, 32'hFFFF_FFE9);
        add_check(1, 8, 32'hFFFF_FFF5);
        build_random_row(2, "random add sub and or", {3'b110, 3'b111, 3'b000, 3'b000},
                         4'b0010, 4'b0000);
        build_random_row(3, "random xor slt sltu sll", {3'b001, 3'b011, 3'b010, 3'b100},
                         4'b0000, 4'b0000);
        build_random_row(4, "random srl sra slt sltu", {3'b011, 3'b010, 3'b101, 3'b101},
                         4'b0010, 4'b1100);
        // Taken BEQ at 8 jumps to 20, BNE at 20 falls through
        test_name[5] = "branches";
        prog[5][0] = enc_addi(1, 0, 3);
        prog[5][1] = enc_addi(2, 0, 3);
        prog[5][2] = enc_branch(3'b000, 1, 2, 12);
        prog[5][3] = enc_addi(3, 0, 1);
        prog[5][4] = enc_addi(4, 0, 2);
        prog[5][5] = enc_branch(3'b001, 1, 2, 8);
        prog[5][6] = enc_addi(5, 0, 9);
        prog[5][7] = enc_addi(6, 5, 1);
        add_check(5, 1, 32'd3);
        add_check(5, 2, 32'd3);
        add_check(5, 3, 32'd0);
        add_check(5, 4, 32'd0);
        add_check(5, 5, 32'd9);
        add_check(5, 6, 32'd10);
        test_name[6] = "jal";
        prog[6][0] = enc_addi(1, 0, 1);
        prog[6][1] = enc_jal(5, 12);
        prog[6][2] = enc_addi(2, 0, 2);
        prog[6][3] = enc_addi(3, 0, 3);
        prog[6][4] = enc_addi(0, 0, 7);
        // Reads x0 right behind the write to it
        prog[6][5] = enc_r(7'h00, 0, 5, 3'b000, 4);
        prog[6][6] = enc_jal(0, 8);
        prog[6][7] = enc_addi(6, 0, 6);
        add_check(6, 0, 32'd0);
        add_check(6, 1, 32'd1);
        add_check(6, 2, 32'd0);
        add_check(6, 3, 32'd0);
        add_check(6, 4, 32'd8);
        add_check(6, 5, 32'd8);
        add_check(6, 6, 32'd0);
        // Same chain with a clock-enable pause
        test_name[7] = "clk_enable pause";
        pause_run[7] = 1'b1;
        for (int w = 0; w < PROG_WORDS; w++) begin
            prog[7][w] = prog[1][w];
        end
        for (int k = 0; k < n_checks[1]; k++) begin
            add_check(7, check_reg[1][k], check_val[1][k]);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("ERR %0t %s: expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arst_n         = 1'b0;
        clk_enable     = 1'b1;
        debug_reg_addr = 5'd0;
        repeat (5) @(posedge clk);
        #1;
        arst_n = 1'b1;
    endtask

    task automatic run_test(input int t);
        int errors_before;
        errors_before = errors;
        cur_test      = t;
        apply_reset();
        #5;
        check_word("debug_pc", `RESET_PC, debug_pc);
        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge clk);
            #1;
            if (pause_run[t]) begin
                // Straight-line program steps pc by 4 per enabled edge
                if (c == 4) begin
                    held_pc    = 32'(4 * (c + 1));
                    clk_enable = 1'b0;
                end
                if (c >= 4 && c <= 14) begin
                    check_word("debug_pc", held_pc, debug_pc);
                end
                if (c == 14) clk_enable = 1'b1;
            end
        end
        for (int k = 0; k < n_checks[t]; k++) begin
            @(posedge clk);
            #1;
            debug_reg_addr = check_reg[t][k];
            #19;
            check_word($sformatf("debug_reg_data x%0d", check_reg[t][k]), check_val[t][k],
                       debug_reg_data);
        end
        if (errors == errors_before) begin
            $display("test %0d %s: ok", t, test_name[t]);
        end else begin
            $display("test %0d %s: %0d errors", t, test_name[t], errors - errors_before);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Instruction memory follows the pc
    initial begin
        instr = `NOP_INSTR;
        forever begin
            @(posedge clk);
            #1;
            instr = fetch_word(debug_pc);
        end
    end

    initial begin
        cycles = 0;
        while (cycles <= TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Simulation timed out after %0d cycles", cycles);
        $display("Regression failed");
        $finish;
    end

    initial begin
        arst_n         = 1'b0;
        clk_enable     = 1'b1;
        debug_reg_addr = 5'd0;
        errors         = 0;
        checks         = 0;
        cur_test       = 0;
        lcg_state      = 32'd35047;
        build_table();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* filelist.f */
+incdir+.
rv_core_pkg.sv
fetch_stage.sv
decode_stage.sv
forward_unit.sv
execute_stage.sv
retire_stage.sv
rv_core.sv
rv_core_tb.sv
